// File: design/core_config.svh
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

// Datapath and address width
`define CORE_WORD_W 32

`define CORE_REG_COUNT 16
`define CORE_REG_W 4

// First fetch address out of reset
`define CORE_RESET_PC 32'h0000_0000

`endif

// File: design/core_pkg.sv
`include "core_config.svh"

package core_pkg;

	typedef logic [`CORE_WORD_W-1:0] word_t;
	typedef logic [`CORE_REG_W-1:0] reg_num_t;
	typedef logic [3:0] flags_t; // N Z C V, MSB first

	// ARM condition field, bits 31:28
	typedef enum logic [3:0] {
		COND_EQ = 4'h0, COND_NE, COND_CS, COND_CC,
		COND_MI, COND_PL, COND_VS, COND_VC,
		COND_HI, COND_LS, COND_GE, COND_LT,
		COND_GT, COND_LE, COND_AL
	} cond_t;

	// Data processing opcode, bits 24:21
	typedef enum logic [3:0] {
		ALU_AND = 4'h0,
		ALU_EOR = 4'h1,
		ALU_SUB = 4'h2,
		ALU_ADD = 4'h4,
		ALU_ORR = 4'hc,
		ALU_MOV = 4'hd
	} alu_op_t;

endpackage

// File: design/fetch.sv
`timescale 1ns/1ps
`include "core_config.svh"

module fetch import core_pkg::*; (
	input  logic  clk,
	input  logic  reset,
	output logic  insn_req,
	output word_t insn_addr,
	input  logic  insn_wait,
	input  word_t insn_data,
	input  logic  issue_stall,
	input  logic  flush,
	input  word_t flush_pc,
	output logic  bubble_1a,
	output word_t insn_1a,
	output word_t pc_1a
);
	word_t pc;
	word_t req_pc;
	word_t held_insn;
	word_t held_pc;
	logic  fetch_en;
	logic  data_valid;
	logic  held_valid;
	logic  accept;

	assign insn_req = fetch_en && !issue_stall;
	assign insn_addr = pc;
	assign accept = insn_req && !insn_wait;

	// Held word wins, it is older than anything on insn_data
	assign bubble_1a = !(held_valid || data_valid);
	assign insn_1a = held_valid ? held_insn : insn_data;
	assign pc_1a = held_valid ? held_pc : req_pc;

	always_ff @(posedge clk) begin
		if (reset) begin
			fetch_en <= 1'b0;
			pc <= `CORE_RESET_PC;
			data_valid <= 1'b0;
			held_valid <= 1'b0;
		end else begin
			fetch_en <= 1'b1;
			data_valid <= accept && !flush; // Wrong-path return becomes a bubble
			if (flush)
				pc <= flush_pc;
			else if (accept)
				pc <= pc + word_t'(4);
			if (flush || !issue_stall)
				held_valid <= 1'b0;
			else
				held_valid <= !bubble_1a;
		end
	end

	always_ff @(posedge clk) begin
		if (accept)
			req_pc <= pc;
		if (issue_stall && !held_valid) begin
			held_insn <= insn_data; // Capture before the bus drops it
			held_pc <= req_pc;
		end
	end

endmodule

// File: design/issue.sv
`timescale 1ns/1ps

module issue import core_pkg::*; (
	input  logic  clk,
	input  logic  reset,
	input  logic  ex_stall,
	input  logic  flush,
	input  logic  bubble_1a,
	input  word_t insn_1a,
	input  word_t pc_1a,
	output logic  issue_stall,
	output logic  bubble_2a,
	output word_t insn_2a,
	output word_t pc_2a
);
	logic       is_dp;
	logic       is_store;
	logic       uses_rm;
	logic       needs_flags;
	logic       hazard;
	logic       issuing;
	reg_num_t   rn;
	reg_num_t   rd;
	reg_num_t   rm;
	logic [1:0] rec_wr; // Entry 0 sits in execute, entry 1 in memory stage
	logic [1:0] rec_fl;
	reg_num_t   rec_num [2];

	function automatic logic pending(input reg_num_t r);
		pending = (rec_wr[0] && rec_num[0] == r) || (rec_wr[1] && rec_num[1] == r);
	endfunction

	assign is_dp = insn_1a[27:26] == 2'b00;
	assign is_store = insn_1a[27:26] == 2'b01 && !insn_1a[20];
	assign uses_rm = is_dp && !insn_1a[25];
	assign needs_flags = cond_t'(insn_1a[31:28]) != COND_AL ||
		(is_dp && insn_1a[20]); // S logic ops carry the old C and V
	assign rn = insn_1a[19:16];
	assign rd = insn_1a[15:12];
	assign rm = insn_1a[3:0];

	// Older writers still ahead of register read
	always_comb begin
		hazard = ((is_dp || is_store) && pending(rn)) ||
			(uses_rm && pending(rm)) ||
			(is_store && pending(rd)) ||
			(needs_flags && |rec_fl);
	end

	assign issuing = !bubble_1a && !hazard;
	assign issue_stall = ex_stall || (!bubble_1a && hazard);

	always_ff @(posedge clk) begin
		if (reset || flush) begin
			bubble_2a <= 1'b1;
			rec_wr <= 2'b00;
			rec_fl <= 2'b00;
		end else if (!ex_stall) begin
			bubble_2a <= !issuing;
			rec_wr <= {rec_wr[0], issuing && is_dp};
			rec_fl <= {rec_fl[0], issuing && is_dp && insn_1a[20]}; // S bit
		end
	end

	always_ff @(posedge clk) begin
		if (!ex_stall) begin
			insn_2a <= insn_1a;
			pc_2a <= pc_1a;
			rec_num[1] <= rec_num[0];
			rec_num[0] <= rd;
		end
	end

endmodule

// File: design/reg_file.sv
`timescale 1ns/1ps
`include "core_config.svh"

module reg_file import core_pkg::*; (
	input  logic     clk,
	input  logic     reset,
	input  reg_num_t read_a_num,
	input  reg_num_t read_b_num,
	output word_t    read_a,
	output word_t    read_b,
	input  logic     write_en,
	input  reg_num_t write_num,
	input  word_t    write_data
);
	word_t regs [`CORE_REG_COUNT];

	// Bypass the write in flight so decode sees the retiring value
	function automatic word_t read_port(input reg_num_t num);
		if (write_en && write_num == num)
			read_port = write_data;
		else
			read_port = regs[num];
	endfunction

	always_comb begin
		read_a = read_port(read_a_num);
		read_b = read_port(read_b_num);
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < `CORE_REG_COUNT; i++)
				regs[i] <= '0;
		end else if (write_en) begin
			regs[write_num] <= write_data;
		end
	end

endmodule

// File: design/decode.sv
`timescale 1ns/1ps

module decode import core_pkg::*; (
	input  logic     clk,
	input  logic     ex_stall,
	input  word_t    insn_1a,
	output reg_num_t read_a_num,
	output reg_num_t read_b_num,
	input  word_t    read_a,
	input  word_t    read_b,
	output word_t    op_a_2a,
	output word_t    op_b_2a,
	output word_t    store_data_2a
);
	logic  is_store;
	logic  is_imm;
	word_t imm8;
	word_t imm12;
	word_t op_b;

	assign is_store = insn_1a[27:26] == 2'b01;
	assign is_imm = insn_1a[25];
	assign imm8 = word_t'(insn_1a[7:0]); // Zero extended, no rotate
	assign imm12 = word_t'(insn_1a[11:0]);

	assign read_a_num = insn_1a[19:16]; // Rn
	assign read_b_num = is_store ? insn_1a[15:12] : insn_1a[3:0]; // Rd for stores, else Rm

	always_comb begin
		if (is_store)
			op_b = insn_1a[23] ? imm12 : -imm12; // U picks add or subtract
		else if (is_imm)
			op_b = imm8;
		else
			op_b = read_b;
	end

	always_ff @(posedge clk) begin
		if (!ex_stall) begin
			op_a_2a <= read_a;
			op_b_2a <= op_b;
			store_data_2a <= read_b;
		end
	end

endmodule

// File: design/execute.sv
`timescale 1ns/1ps
`include "core_config.svh"

module execute import core_pkg::*; (
	input  logic     clk,
	input  logic     reset,
	input  logic     mem_stall,
	input  flags_t   flags,
	input  logic     bubble_2a,
	input  word_t    insn_2a,
	input  word_t    pc_2a,
	input  word_t    op_a_2a,
	input  word_t    op_b_2a,
	input  word_t    store_data_2a,
	output logic     ex_stall,
	output logic     flush,
	output word_t    flush_pc,
	output logic     bubble_3a,
	output logic     write_en_3a,
	output reg_num_t write_num_3a,
	output word_t    result_3a,
	output logic     flags_en_3a,
	output flags_t   flags_3a,
	output logic     store_en_3a,
	output word_t    store_data_3a
);
	localparam int MSB = `CORE_WORD_W - 1;

	cond_t          cond;
	alu_op_t        op;
	logic           is_dp;
	logic           is_store;
	logic           is_branch;
	logic           cond_ok;
	logic           exec;
	logic           op_ok;
	logic [MSB+1:0] sum;
	logic [MSB+1:0] diff;
	word_t          alu_out;
	flags_t         alu_flags;
	word_t          br_offset;

	assign cond = cond_t'(insn_2a[31:28]);
	assign op = alu_op_t'(insn_2a[24:21]);
	assign is_dp = insn_2a[27:26] == 2'b00;
	assign is_store = insn_2a[27:26] == 2'b01 && !insn_2a[20];
	assign is_branch = insn_2a[27:25] == 3'b101;
	assign exec = !bubble_2a && cond_ok;

	// flags is {N, Z, C, V}
	always_comb begin
		case (cond)
		COND_EQ: cond_ok = flags[2];
		COND_NE: cond_ok = !flags[2];
		COND_CS: cond_ok = flags[1];
		COND_CC: cond_ok = !flags[1];
		COND_MI: cond_ok = flags[3];
		COND_PL: cond_ok = !flags[3];
		COND_VS: cond_ok = flags[0];
		COND_VC: cond_ok = !flags[0];
		COND_HI: cond_ok = flags[1] && !flags[2];
		COND_LS: cond_ok = !flags[1] || flags[2];
		COND_GE: cond_ok = flags[3] == flags[0];
		COND_LT: cond_ok = flags[3] != flags[0];
		COND_GT: cond_ok = !flags[2] && flags[3] == flags[0];
		COND_LE: cond_ok = flags[2] || flags[3] != flags[0];
		COND_AL: cond_ok = 1'b1;
		default: cond_ok = 1'b0;
		endcase
	end

	assign sum = {1'b0, op_a_2a} + {1'b0, op_b_2a}; // Also the store address
	assign diff = {1'b0, op_a_2a} + {1'b0, ~op_b_2a} + 1'b1; // Carry out is no-borrow

	always_comb begin
		op_ok = 1'b1;
		alu_out = op_b_2a;
		alu_flags = flags; // C and V pass through for logical ops
		case (op)
		ALU_AND: alu_out = op_a_2a & op_b_2a;
		ALU_EOR: alu_out = op_a_2a ^ op_b_2a;
		ALU_ORR: alu_out = op_a_2a | op_b_2a;
		ALU_MOV: alu_out = op_b_2a;
		ALU_ADD: begin
			alu_out = sum[MSB:0];
			alu_flags[1] = sum[MSB+1];
			alu_flags[0] = op_a_2a[MSB] == op_b_2a[MSB] && sum[MSB] != op_a_2a[MSB];
		end
		ALU_SUB: begin
			alu_out = diff[MSB:0];
			alu_flags[1] = diff[MSB+1];
			alu_flags[0] = op_a_2a[MSB] != op_b_2a[MSB] && diff[MSB] != op_a_2a[MSB];
		end
		default: op_ok = 1'b0; // Unsupported opcode retires with no effect
		endcase
		alu_flags[3] = alu_out[MSB];
		alu_flags[2] = alu_out == '0;
	end

	// PC + 8 + signed word offset
	assign br_offset = {{(`CORE_WORD_W - 26){insn_2a[23]}}, insn_2a[23:0], 2'b00};
	assign flush_pc = pc_2a + word_t'(8) + br_offset;
	assign flush = exec && is_branch && !mem_stall; // Only once the branch moves on
	assign ex_stall = mem_stall;

	always_ff @(posedge clk) begin
		if (reset) begin
			bubble_3a <= 1'b1;
			write_en_3a <= 1'b0;
			flags_en_3a <= 1'b0;
			store_en_3a <= 1'b0;
		end else if (!mem_stall) begin
			bubble_3a <= bubble_2a || is_branch;
			write_en_3a <= exec && is_dp && op_ok;
			flags_en_3a <= exec && is_dp && op_ok && insn_2a[20];
			store_en_3a <= exec && is_store;
		end
	end

	always_ff @(posedge clk) begin
		if (!mem_stall) begin
			write_num_3a <= insn_2a[15:12];
			result_3a <= is_store ? sum[MSB:0] : alu_out;
			flags_3a <= alu_flags;
			store_data_3a <= store_data_2a;
		end
	end

endmodule

// File: design/memory_stage.sv
`timescale 1ns/1ps

module memory_stage import core_pkg::*; (
	input  logic     clk,
	input  logic     reset,
	input  logic     bubble_3a,
	input  logic     write_en_3a,
	input  reg_num_t write_num_3a,
	input  word_t    result_3a,
	input  logic     flags_en_3a,
	input  flags_t   flags_3a,
	input  logic     store_en_3a,
	input  word_t    store_data_3a,
	output logic     mem_stall,
	output logic     store_valid,
	output word_t    store_addr,
	output word_t    store_data,
	input  logic     store_busy,
	output logic     write_en,
	output reg_num_t write_num,
	output word_t    write_data,
	output flags_t   flags
);
	// Store waits here until the port takes it
	assign mem_stall = store_valid && store_busy;

	always_ff @(posedge clk) begin
		if (reset) begin
			store_valid <= 1'b0;
			write_en <= 1'b0;
			flags <= '0;
		end else if (!mem_stall) begin
			store_valid <= !bubble_3a && store_en_3a;
			write_en <= !bubble_3a && write_en_3a;
			if (!bubble_3a && flags_en_3a)
				flags <= flags_3a; // CPSR update
		end
	end

	always_ff @(posedge clk) begin
		if (!mem_stall) begin
			store_addr <= result_3a;
			store_data <= store_data_3a;
			write_num <= write_num_3a;
			write_data <= result_3a;
		end
	end

endmodule

// File: design/core.sv
`timescale 1ns/1ps

module core import core_pkg::*; (
	input  logic  clk,
	input  logic  reset,
	output logic  insn_req,
	output word_t insn_addr,
	input  logic  insn_wait,
	input  word_t insn_data,
	output logic  store_valid,
	output word_t store_addr,
	output word_t store_data,
	input  logic  store_busy
);
	logic     issue_stall;
	logic     ex_stall;
	logic     mem_stall;
	logic     flush;
	word_t    flush_pc;
	logic     bubble_1a;
	word_t    insn_1a;
	word_t    pc_1a;
	logic     bubble_2a;
	word_t    insn_2a;
	word_t    pc_2a;
	reg_num_t read_a_num;
	reg_num_t read_b_num;
	word_t    read_a;
	word_t    read_b;
	word_t    op_a_2a;
	word_t    op_b_2a;
	word_t    store_data_2a;
	logic     bubble_3a;
	logic     write_en_3a;
	reg_num_t write_num_3a;
	word_t    result_3a;
	logic     flags_en_3a;
	flags_t   flags_3a;
	logic     store_en_3a;
	word_t    store_data_3a;
	logic     write_en;
	reg_num_t write_num;
	word_t    write_data;
	flags_t   flags; // Retired CPSR flags

	fetch fetch_inst (.clk, .reset, .insn_req, .insn_addr, .insn_wait, .insn_data,
		.issue_stall, .flush, .flush_pc, .bubble_1a, .insn_1a, .pc_1a);

	issue issue_inst (.clk, .reset, .ex_stall, .flush, .bubble_1a, .insn_1a, .pc_1a,
		.issue_stall, .bubble_2a, .insn_2a, .pc_2a);

	reg_file reg_file_inst (.clk, .reset, .read_a_num, .read_b_num, .read_a, .read_b,
		.write_en, .write_num, .write_data);

	decode decode_inst (.clk, .ex_stall, .insn_1a, .read_a_num, .read_b_num,
		.read_a, .read_b, .op_a_2a, .op_b_2a, .store_data_2a);

	execute execute_inst (.clk, .reset, .mem_stall, .flags, .bubble_2a, .insn_2a, .pc_2a,
		.op_a_2a, .op_b_2a, .store_data_2a, .ex_stall, .flush, .flush_pc,
		.bubble_3a, .write_en_3a, .write_num_3a, .result_3a, .flags_en_3a, .flags_3a,
		.store_en_3a, .store_data_3a);

	memory_stage memory_stage_inst (.clk, .reset, .bubble_3a, .write_en_3a, .write_num_3a,
		.result_3a, .flags_en_3a, .flags_3a, .store_en_3a, .store_data_3a, .mem_stall,
		.store_valid, .store_addr, .store_data, .store_busy,
		.write_en, .write_num, .write_data, .flags);

endmodule

// File: tb/core_tb.sv
`timescale 1ns/1ps

module core_tb import core_pkg::*; ();
	localparam logic [31:0] SEED = 32'h589f_4eb7;
	localparam int RANDOM_COUNT = 200;
	localparam int PROG_LEN = RANDOM_COUNT + 2; // Random part, final store, branch-to-self
	localparam int MEM_WORDS = 512;
	localparam int DRAIN_CYCLES = 20;
	localparam int TIMEOUT_CYCLES = PROG_LEN * 20 + 4 + DRAIN_CYCLES;

	logic  clk = 1'b0;
	logic  reset;
	logic  insn_req;
	word_t insn_addr;
	logic  insn_wait;
	word_t insn_data;
	logic  store_valid;
	word_t store_addr;
	word_t store_data;
	logic  store_busy;

	word_t imem [MEM_WORDS];
	word_t exp_addr [$];
	word_t exp_data [$];
	int    store_count = 0;
	int    value_errors = 0;
	int    other_errors = 0;
	int    cycle_count = 0;

	core core_inst (.clk, .reset, .insn_req, .insn_addr, .insn_wait, .insn_data,
		.store_valid, .store_addr, .store_data, .store_busy);

	always #20 clk = ~clk;

	task automatic compare_word(input string test, input word_t expected, input word_t actual);
		if (expected !== actual) begin
			$display("Fail %s expected %h actual %h", test, expected, actual);
			value_errors++;
		end
	endtask

	function automatic logic [3:0] random_cond();
		if ($urandom_range(0, 99) < 60)
			return COND_AL;
		return 4'($urandom_range(0, 13)); // EQ up to LE
	endfunction

	function automatic logic [3:0] random_reg();
		return 4'($urandom_range(0, 14)); // Never r15
	endfunction

	function automatic logic [3:0] random_opcode();
		case ($urandom_range(0, 5))
		0: return ALU_AND;
		1: return ALU_EOR;
		2: return ALU_SUB;
		3: return ALU_ADD;
		4: return ALU_ORR;
		default: return ALU_MOV;
		endcase
	endfunction

	function automatic word_t make_dp();
		logic [3:0]  cond;
		logic        imm;
		logic        set_flags;
		logic [11:0] operand;
		cond = random_cond();
		imm = 1'($urandom_range(0, 1));
		set_flags = $urandom_range(0, 99) < 40;
		operand = imm ? {4'h0, 8'($urandom_range(0, 255))} : {8'h00, random_reg()};
		return {cond, 2'b00, imm, random_opcode(), set_flags, random_reg(), random_reg(), operand};
	endfunction

	// Immediate offset, pre-indexed, no writeback
	function automatic word_t make_store(input logic [3:0] cond);
		logic up;
		up = 1'($urandom_range(0, 1));
		return {cond, 2'b01, 1'b0, 1'b1, up, 3'b000, random_reg(), random_reg(),
			12'($urandom_range(0, 4095))};
	endfunction

	// Skips the next 1 to 3 words
	function automatic word_t make_branch(input logic [3:0] cond, input int skip);
		return {cond, 3'b101, 1'b0, 24'(skip - 1)};
	endfunction

	task automatic build_program();
		int kind;
		int skip;
		for (int i = 0; i < MEM_WORDS; i++)
			imem[i] = {4'hf, 4'h0, 24'(i)}; // Never-condition filler, only seen on wrong paths
		for (int i = 0; i < RANDOM_COUNT; i++) begin
			kind = $urandom_range(0, 99);
			skip = $urandom_range(1, 3);
			if (kind < 20 && i + 1 + skip <= RANDOM_COUNT)
				imem[i] = make_branch(random_cond(), skip);
			else if (kind < 45)
				imem[i] = make_store(random_cond());
			else
				imem[i] = make_dp();
		end
		imem[RANDOM_COUNT] = make_store(COND_AL); // Last store marks the end of the program
		imem[RANDOM_COUNT + 1] = {COND_AL, 3'b101, 1'b0, 24'hff_fffe};
	endtask

	function automatic logic cond_passes(input logic [3:0] cond, input logic n, z, c, v);
		case (cond)
		COND_EQ: return z;
		COND_NE: return !z;
		COND_CS: return c;
		COND_CC: return !c;
		COND_MI: return n;
		COND_PL: return !n;
		COND_VS: return v;
		COND_VC: return !v;
		COND_HI: return c && !z;
		COND_LS: return !c || z;
		COND_GE: return n == v;
		COND_LT: return n != v;
		COND_GT: return !z && n == v;
		COND_LE: return z || n != v;
		COND_AL: return 1'b1;
		default: return 1'b0;
		endcase
	endfunction

	// Architectural model, fills the expected store list
	task automatic run_model();
		word_t       model_regs [15];
		word_t       pc;
		word_t       insn;
		word_t       a;
		word_t       b;
		word_t       r;
		word_t       offset;
		logic [32:0] wide;
		logic        n;
		logic        z;
		logic        c;
		logic        v;
		int          steps;
		for (int i = 0; i < 15; i++)
			model_regs[i] = '0;
		n = 1'b0;
		z = 1'b0;
		c = 1'b0;
		v = 1'b0;
		pc = '0;
		steps = 0;
		wide = '0;
		while (pc != word_t'((RANDOM_COUNT + 1) * 4) && steps < 10 * PROG_LEN) begin
			insn = imem[pc[10:2]];
			steps++;
			if (!cond_passes(insn[31:28], n, z, c, v)) begin
				pc = pc + 4;
			end else if (insn[27:25] == 3'b101) begin
				offset = {{6{insn[23]}}, insn[23:0], 2'b00};
				pc = pc + 8 + offset;
			end else if (insn[27:26] == 2'b01) begin
				offset = word_t'(insn[11:0]);
				a = model_regs[insn[19:16]];
				exp_addr.push_back(insn[23] ? a + offset : a - offset);
				exp_data.push_back(model_regs[insn[15:12]]);
				pc = pc + 4;
			end else begin
				a = model_regs[insn[19:16]];
				b = insn[25] ? word_t'(insn[7:0]) : model_regs[insn[3:0]];
				case (insn[24:21])
				ALU_AND: r = a & b;
				ALU_EOR: r = a ^ b;
				ALU_ORR: r = a | b;
				ALU_MOV: r = b;
				ALU_ADD: begin
					wide = {1'b0, a} + {1'b0, b};
					r = wide[31:0];
				end
				ALU_SUB: r = a - b;
				default: r = '0;
				endcase
				model_regs[insn[15:12]] = r;
				if (insn[20]) begin
					n = r[31];
					z = r == '0;
					if (insn[24:21] == ALU_ADD) begin
						c = wide[32];
						v = a[31] == b[31] && r[31] != a[31];
					end else if (insn[24:21] == ALU_SUB) begin
						c = a >= b; // No borrow
						v = a[31] != b[31] && r[31] != a[31];
					end
				end
				pc = pc + 4;
			end
		end
		if (steps >= 10 * PROG_LEN) begin
			$display("ISA model never reached the final branch");
			other_errors++;
		end
	endtask

	// Random waits and back-pressure, instruction memory answers the cycle after a request
	always @(posedge clk) begin
		insn_wait <= $urandom_range(0, 99) < 25;
		store_busy <= $urandom_range(0, 99) < 30;
		if (insn_req && !insn_wait)
			insn_data <= imem[insn_addr[10:2]];
	end

	always @(posedge clk) begin
		if (!reset && store_valid && !store_busy) begin
			if (store_count < exp_addr.size()) begin
				compare_word($sformatf("store %0d address", store_count),
					exp_addr[store_count], store_addr);
				compare_word($sformatf("store %0d data", store_count),
					exp_data[store_count], store_data);
			end else begin
				$display("Store to %h beyond the %0d expected stores", store_addr,
					exp_addr.size());
				other_errors++;
			end
			store_count <= store_count + 1;
		end
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Timeout after %0d cycles with %0d of %0d stores seen", cycle_count,
				store_count, exp_addr.size());
			$display("Something failed");
			$finish;
		end
	end

	initial begin
		reset = 1'b1;
		insn_wait = 1'b0;
		insn_data = '0;
		store_busy = 1'b0;
		void'($urandom(SEED));
		build_program();
		run_model();
		repeat (4) @(posedge clk);
		reset <= 1'b0;
		while (store_count < exp_addr.size())
			@(posedge clk);
		repeat (DRAIN_CYCLES) @(posedge clk); // Catch repeated stores after the last one
		$display("Stores seen %0d, expected %0d, value errors %0d, other errors %0d",
			store_count, exp_addr.size(), value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0 && store_count == exp_addr.size())
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

// File: tb.f
+incdir+design
design/core_pkg.sv
design/fetch.sv
design/issue.sv
design/reg_file.sv
design/decode.sv
design/execute.sv
design/memory_stage.sv
design/core.sv
tb/core_tb.sv

// File: run.sh
#!/bin/bash
# Build the core testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f tb.f --top-module core_tb -o core_tb
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/core_tb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qx "Everything OK"; then
	exit 0
fi
exit 1
